// File: include/alloc_config.svh
// ----------------------------------------------------------
// Allocator configuration
// Widths and register map offsets for the pointer allocator
// ----------------------------------------------------------
`ifndef ALLOC_CONFIG_SVH
`define ALLOC_CONFIG_SVH

`define ALLOC_PTR_W   4
`define ALLOC_CNT_W   32
`define ALLOC_DATA_W  32
`define ALLOC_ADDR_W  8
`define ALLOC_NUM_CNT 6

// Register offsets
`define REG_CONTROL          8'h00
`define REG_STATUS           8'h04
`define REG_FLAGS            8'h08
`define REG_ALLOC_ERR_PTR    8'h0C
`define REG_DEALLOC_ERR_PTR  8'h10
`define REG_CNT_ACTIVE       8'h14
`define REG_DBG_STATUS       8'h18
`define REG_DBG_CONTROL      8'h1C
`define REG_CNT_ALLOC        8'h20
`define REG_CNT_ALLOC_FAIL   8'h24
`define REG_CNT_ALLOC_ERR    8'h28
`define REG_CNT_DEALLOC      8'h2C
`define REG_CNT_DEALLOC_FAIL 8'h30
`define REG_CNT_DEALLOC_ERR  8'h34
`define REG_INFO_SIZE        8'h38

`endif

// File: hdl/alloc_pkg.sv
// ----------------------------------------------------------
// Allocator package
// Shared types for the allocator and its register block
// ----------------------------------------------------------
`include "alloc_config.svh"

package alloc_pkg;

    // Pointer into the pool
    typedef logic [`ALLOC_PTR_W-1:0] ptr_t;

    // Debug counter
    typedef logic [`ALLOC_CNT_W-1:0] cnt_t;

    // Register port
    typedef logic [`ALLOC_DATA_W-1:0] reg_data_t;
    typedef logic [`ALLOC_ADDR_W-1:0] reg_addr_t;

    // One bit wider than a pointer so a full pool fits
    typedef logic [`ALLOC_PTR_W:0] active_cnt_t;

    // Allocator FSM, 8 bits wide for the debug status register
    typedef enum logic [7:0] {
        ST_RESET = 8'd0,
        ST_INIT  = 8'd1,
        ST_READY = 8'd2
    } alloc_state_t;

endpackage : alloc_pkg

// File: hdl/alloc_mon_if.sv
// ----------------------------------------------------------
// Allocator monitor interface
// Event pulses and the pointer involved in each event
// ----------------------------------------------------------
`timescale 1ns/1ps

interface alloc_mon_if;
    import alloc_pkg::*;

    logic alloc;
    logic alloc_fail;
    logic alloc_err;
    logic dealloc;
    logic dealloc_fail;
    logic dealloc_err;
    ptr_t ptr;

    modport peripheral (
        output alloc, alloc_fail, alloc_err, dealloc, dealloc_fail, dealloc_err, ptr
    );

    modport controller (
        input alloc, alloc_fail, alloc_err, dealloc, dealloc_fail, dealloc_err, ptr
    );

endinterface : alloc_mon_if

// File: hdl/alloc_reg_if.sv
// ----------------------------------------------------------
// Register interface
// Register values from the block, next values from the core
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "alloc_config.svh"

interface alloc_reg_if;
    import alloc_pkg::*;

    // Control register and debug control pulse
    logic control_reset;
    logic control_enable;
    logic control_alloc_en;
    logic clear_counts;

    // Values read back by the core
    logic [1:0]  flags;
    logic        flags_rd_evt;
    active_cnt_t cnt_active;
    cnt_t        cnt [`ALLOC_NUM_CNT];

    // Next values and their load strobes
    logic [2:0]   status_nxt;
    logic         status_nxt_v;
    logic [1:0]   flags_nxt;
    logic         flags_nxt_v;
    ptr_t         alloc_err_ptr_nxt;
    logic         alloc_err_ptr_nxt_v;
    ptr_t         dealloc_err_ptr_nxt;
    logic         dealloc_err_ptr_nxt_v;
    active_cnt_t  cnt_active_nxt;
    logic         cnt_active_nxt_v;
    alloc_state_t dbg_status_nxt;
    logic         dbg_status_nxt_v;
    cnt_t         cnt_nxt [`ALLOC_NUM_CNT];
    logic [`ALLOC_NUM_CNT-1:0] cnt_nxt_v;

    modport core (
        input  control_reset, control_enable, control_alloc_en, clear_counts,
        input  flags, flags_rd_evt, cnt_active, cnt,
        output status_nxt, status_nxt_v, flags_nxt, flags_nxt_v,
        output alloc_err_ptr_nxt, alloc_err_ptr_nxt_v,
        output dealloc_err_ptr_nxt, dealloc_err_ptr_nxt_v,
        output cnt_active_nxt, cnt_active_nxt_v, dbg_status_nxt, dbg_status_nxt_v,
        output cnt_nxt, cnt_nxt_v
    );

    modport blk (
        output control_reset, control_enable, control_alloc_en, clear_counts,
        output flags, flags_rd_evt, cnt_active, cnt,
        input  status_nxt, status_nxt_v, flags_nxt, flags_nxt_v,
        input  alloc_err_ptr_nxt, alloc_err_ptr_nxt_v,
        input  dealloc_err_ptr_nxt, dealloc_err_ptr_nxt_v,
        input  cnt_active_nxt, cnt_active_nxt_v, dbg_status_nxt, dbg_status_nxt_v,
        input  cnt_nxt, cnt_nxt_v
    );

endinterface : alloc_reg_if

// File: hdl/alloc_ptr_allocator.sv
// ----------------------------------------------------------
// Pointer allocator
// Free bitmap with init sweep, lowest-free allocation and
// classification of every request into one monitor event
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "alloc_config.svh"

module alloc_ptr_allocator (
    input  logic                  clk,
    input  logic                  ctrl_reset,
    input  logic                  ctrl_en,
    input  logic                  ctrl_alloc_en,
    input  logic                  alloc_req,
    input  logic                  dealloc_req,
    input  alloc_pkg::ptr_t       dealloc_ptr,
    output logic                  alloc_gnt,
    output logic                  alloc_nack,
    output alloc_pkg::ptr_t       alloc_ptr,
    output logic                  init_done,
    output alloc_pkg::alloc_state_t state,
    alloc_mon_if.peripheral       mon_if
);
    import alloc_pkg::*;

    localparam int NUM_PTRS = 1 << `ALLOC_PTR_W;

    // Bit set means the pointer is allocated
    logic [NUM_PTRS-1:0] alloc_map;
    ptr_t init_ptr;
    ptr_t free_ptr;
    logic any_free;
    logic ready;
    logic alloc_ok;
    logic grant;
    logic dealloc_ok;
    ptr_t evt_ptr;

    // ------------------------------------------------------
    // FSM and init sweep
    // ------------------------------------------------------
    always_ff @(posedge clk) begin
        if (ctrl_reset) begin
            state    <= ST_RESET;
            init_ptr <= '0;
        end else begin
            case (state)
                ST_RESET: if (ctrl_en) state <= ST_INIT;
                ST_INIT: begin
                    init_ptr <= init_ptr + 1'b1;
                    if (&init_ptr) state <= ST_READY;
                end
                default: ;
            endcase
        end
    end

    assign init_done = (state == ST_READY);
    assign ready     = init_done && ctrl_en;

    // Priority search, lowest index wins
    always_comb begin
        free_ptr = '0;
        any_free = 1'b0;
        for (int i = NUM_PTRS - 1; i >= 0; i--) begin
            if (!alloc_map[i]) begin
                free_ptr = ptr_t'(i);
                any_free = 1'b1;
            end
        end
    end

    assign alloc_ok   = alloc_req && ready && ctrl_alloc_en;
    assign grant      = alloc_ok && any_free;
    assign dealloc_ok = dealloc_req && ready && alloc_map[dealloc_ptr];

    always_ff @(posedge clk) begin
        if (state == ST_INIT) begin
            alloc_map[init_ptr] <= 1'b0;
        end else begin
            if (grant) alloc_map[free_ptr] <= 1'b1;
            if (dealloc_ok) alloc_map[dealloc_ptr] <= 1'b0;
        end
    end

    // ------------------------------------------------------
    // Replies and monitor events
    // ------------------------------------------------------
    always_ff @(posedge clk) begin
        if (ctrl_reset) begin
            alloc_gnt           <= 1'b0;
            alloc_nack          <= 1'b0;
            mon_if.alloc        <= 1'b0;
            mon_if.alloc_fail   <= 1'b0;
            mon_if.alloc_err    <= 1'b0;
            mon_if.dealloc      <= 1'b0;
            mon_if.dealloc_fail <= 1'b0;
            mon_if.dealloc_err  <= 1'b0;
        end else begin
            alloc_gnt           <= grant;
            alloc_nack          <= alloc_req && !grant;
            mon_if.alloc        <= grant;
            mon_if.alloc_fail   <= alloc_ok && !any_free;
            mon_if.alloc_err    <= alloc_req && !alloc_ok;
            mon_if.dealloc      <= dealloc_ok;
            mon_if.dealloc_fail <= dealloc_req && !ready;
            mon_if.dealloc_err  <= dealloc_req && ready && !alloc_map[dealloc_ptr];
        end
    end

    // Allocation side owns the event pointer when both requests arrive
    always_ff @(posedge clk) begin
        evt_ptr <= alloc_req ? free_ptr : dealloc_ptr;
    end

    assign alloc_ptr  = evt_ptr;
    assign mon_if.ptr = evt_ptr;

endmodule : alloc_ptr_allocator

// File: hdl/alloc_reg_blk.sv
// ----------------------------------------------------------
// Register block
// Register file, address decode and registered read data
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "alloc_config.svh"

module alloc_reg_blk (
    input  logic                 clk,
    input  logic                 dbg_cnt_reset,
    input  logic                 reg_wr,
    input  logic                 reg_rd,
    input  alloc_pkg::reg_addr_t reg_addr,
    input  alloc_pkg::reg_data_t reg_wdata,
    output alloc_pkg::reg_data_t reg_rdata,
    output logic                 reg_rvalid,
    alloc_reg_if.blk             reg_if
);
    import alloc_pkg::*;

    localparam reg_data_t INFO_SIZE = reg_data_t'(1 << `ALLOC_PTR_W);

    // Registers with no software write path
    logic [2:0]   status;
    ptr_t         alloc_err_ptr;
    ptr_t         dealloc_err_ptr;
    alloc_state_t dbg_status;

    // ------------------------------------------------------
    // Control and debug control writes
    // ------------------------------------------------------
    // Control bits: 0 reset, 1 enable, 2 allocate enable
    always_ff @(posedge clk) begin
        if (dbg_cnt_reset) begin
            reg_if.control_reset    <= 1'b0;
            reg_if.control_enable   <= 1'b0;
            reg_if.control_alloc_en <= 1'b0;
            reg_if.clear_counts     <= 1'b0;
        end else begin
            if (reg_wr && reg_addr == `REG_CONTROL) begin
                reg_if.control_reset    <= reg_wdata[0];
                reg_if.control_enable   <= reg_wdata[1];
                reg_if.control_alloc_en <= reg_wdata[2];
            end
            reg_if.clear_counts <= reg_wr && reg_addr == `REG_DBG_CONTROL && reg_wdata[0];
        end
    end

    // ------------------------------------------------------
    // Status and counter loads
    // ------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reg_if.status_nxt_v) status <= reg_if.status_nxt;
        if (reg_if.flags_nxt_v) reg_if.flags <= reg_if.flags_nxt;
        if (reg_if.alloc_err_ptr_nxt_v) alloc_err_ptr <= reg_if.alloc_err_ptr_nxt;
        if (reg_if.dealloc_err_ptr_nxt_v) dealloc_err_ptr <= reg_if.dealloc_err_ptr_nxt;
        if (reg_if.cnt_active_nxt_v) reg_if.cnt_active <= reg_if.cnt_active_nxt;
        if (reg_if.dbg_status_nxt_v) dbg_status <= reg_if.dbg_status_nxt;
        for (int i = 0; i < `ALLOC_NUM_CNT; i++) begin
            if (reg_if.cnt_nxt_v[i]) reg_if.cnt[i] <= reg_if.cnt_nxt[i];
        end
    end

    // Flags take only new events on the cycle they are read
    assign reg_if.flags_rd_evt = reg_rd && reg_addr == `REG_FLAGS;

    // ------------------------------------------------------
    // Read path
    // ------------------------------------------------------
    always_ff @(posedge clk) begin
        if (dbg_cnt_reset) reg_rvalid <= 1'b0;
        else reg_rvalid <= reg_rd;
    end

    always_ff @(posedge clk) begin
        case (reg_addr)
            `REG_CONTROL: reg_rdata <= reg_data_t'({reg_if.control_alloc_en,
                                                   reg_if.control_enable,
                                                   reg_if.control_reset});
            `REG_STATUS:           reg_rdata <= reg_data_t'(status);
            `REG_FLAGS:            reg_rdata <= reg_data_t'(reg_if.flags);
            `REG_ALLOC_ERR_PTR:    reg_rdata <= reg_data_t'(alloc_err_ptr);
            `REG_DEALLOC_ERR_PTR:  reg_rdata <= reg_data_t'(dealloc_err_ptr);
            `REG_CNT_ACTIVE:       reg_rdata <= reg_data_t'(reg_if.cnt_active);
            `REG_DBG_STATUS:       reg_rdata <= reg_data_t'(dbg_status);
            `REG_CNT_ALLOC:        reg_rdata <= reg_if.cnt[0];
            `REG_CNT_ALLOC_FAIL:   reg_rdata <= reg_if.cnt[1];
            `REG_CNT_ALLOC_ERR:    reg_rdata <= reg_if.cnt[2];
            `REG_CNT_DEALLOC:      reg_rdata <= reg_if.cnt[3];
            `REG_CNT_DEALLOC_FAIL: reg_rdata <= reg_if.cnt[4];
            `REG_CNT_DEALLOC_ERR:  reg_rdata <= reg_if.cnt[5];
            `REG_INFO_SIZE:        reg_rdata <= INFO_SIZE;
            default:               reg_rdata <= '0;
        endcase
    end

endmodule : alloc_reg_blk

// File: hdl/alloc_ctrl_core.sv
// ----------------------------------------------------------
// Allocator control core
// Control outputs, status, error flags, active count and
// clearable debug counters
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "alloc_config.svh"

module alloc_ctrl_core (
    input  logic                    clk,
    input  logic                    dbg_cnt_reset,
    input  logic                    en,
    input  logic                    init_done,
    input  alloc_pkg::alloc_state_t state,
    output logic                    ctrl_reset,
    output logic                    ctrl_en,
    output logic                    ctrl_alloc_en,
    alloc_mon_if.controller         mon_if,
    alloc_reg_if.core               reg_if
);
    import alloc_pkg::*;

    logic alloc_q;
    logic alloc_fail_q;
    logic alloc_err_q;
    logic dealloc_q;
    logic dealloc_fail_q;
    logic dealloc_err_q;
    ptr_t ptr_q;
    logic cnt_clear;
    logic [`ALLOC_NUM_CNT-1:0] cnt_evt;

    // ------------------------------------------------------
    // Monitor stage
    // ------------------------------------------------------
    always_ff @(posedge clk) begin
        if (dbg_cnt_reset) begin
            {alloc_q, alloc_fail_q, alloc_err_q} <= '0;
            {dealloc_q, dealloc_fail_q, dealloc_err_q} <= '0;
        end else begin
            {alloc_q, alloc_fail_q, alloc_err_q} <=
                {mon_if.alloc, mon_if.alloc_fail, mon_if.alloc_err};
            {dealloc_q, dealloc_fail_q, dealloc_err_q} <=
                {mon_if.dealloc, mon_if.dealloc_fail, mon_if.dealloc_err};
        end
        ptr_q <= mon_if.ptr;
    end

    // ------------------------------------------------------
    // Control
    // ------------------------------------------------------
    // Reset buffer, held one cycle past the source
    always_ff @(posedge clk) begin
        ctrl_reset <= dbg_cnt_reset || reg_if.control_reset;
        cnt_clear  <= dbg_cnt_reset || reg_if.control_reset || reg_if.clear_counts;
    end

    always_ff @(posedge clk) begin
        if (dbg_cnt_reset) ctrl_en <= 1'b0;
        else ctrl_en <= en && reg_if.control_enable;
    end

    assign ctrl_alloc_en = reg_if.control_alloc_en;

    // Status bits: 0 reset, 1 init done, 2 enabled
    assign reg_if.status_nxt_v     = 1'b1;
    assign reg_if.status_nxt       = {ctrl_en, init_done, ctrl_reset};
    assign reg_if.dbg_status_nxt_v = 1'b1;
    assign reg_if.dbg_status_nxt   = state;

    // ------------------------------------------------------
    // Error flags and pointers
    // ------------------------------------------------------
    // Flag bits: 0 alloc error, 1 dealloc error
    assign reg_if.flags_nxt_v = 1'b1;
    always_comb begin
        if (ctrl_reset) reg_if.flags_nxt = 2'b00;
        else if (reg_if.flags_rd_evt) reg_if.flags_nxt = {dealloc_err_q, alloc_err_q};
        else reg_if.flags_nxt = reg_if.flags | {dealloc_err_q, alloc_err_q};
    end

    assign reg_if.alloc_err_ptr_nxt_v   = alloc_err_q;
    assign reg_if.alloc_err_ptr_nxt     = ptr_q;
    assign reg_if.dealloc_err_ptr_nxt_v = dealloc_err_q;
    assign reg_if.dealloc_err_ptr_nxt   = ptr_q;

    // Active count moves only on a lone alloc or dealloc
    always_comb begin
        reg_if.cnt_active_nxt_v = ctrl_reset || (alloc_q ^ dealloc_q);
        if (ctrl_reset) reg_if.cnt_active_nxt = '0;
        else if (alloc_q) reg_if.cnt_active_nxt = reg_if.cnt_active + 1'b1;
        else reg_if.cnt_active_nxt = reg_if.cnt_active - 1'b1;
    end

    // ------------------------------------------------------
    // Debug counters, wrapping
    // ------------------------------------------------------
    assign cnt_evt = {dealloc_err_q, dealloc_fail_q, dealloc_q,
                      alloc_err_q, alloc_fail_q, alloc_q};

    always_comb begin
        for (int i = 0; i < `ALLOC_NUM_CNT; i++) begin
            reg_if.cnt_nxt_v[i] = cnt_clear || cnt_evt[i];
            reg_if.cnt_nxt[i]   = cnt_clear ? '0 : reg_if.cnt[i] + 1'b1;
        end
    end

endmodule : alloc_ctrl_core

// File: hdl/alloc_top.sv
// ----------------------------------------------------------
// Allocator top level
// Pointer allocator with its control core and register block
// ----------------------------------------------------------
`timescale 1ns/1ps

module alloc_top (
    input  logic                 clk,
    input  logic                 dbg_cnt_reset,
    // Register port
    input  logic                 reg_wr,
    input  logic                 reg_rd,
    input  alloc_pkg::reg_addr_t reg_addr,
    input  alloc_pkg::reg_data_t reg_wdata,
    output alloc_pkg::reg_data_t reg_rdata,
    output logic                 reg_rvalid,
    // Allocation and deallocation
    input  logic                 alloc_req,
    output logic                 alloc_gnt,
    output alloc_pkg::ptr_t      alloc_ptr,
    output logic                 alloc_nack,
    input  logic                 dealloc_req,
    input  alloc_pkg::ptr_t      dealloc_ptr,
    input  logic                 en
);
    import alloc_pkg::*;

    logic         ctrl_reset;
    logic         ctrl_en;
    logic         ctrl_alloc_en;
    logic         init_done;
    alloc_state_t state;

    alloc_mon_if mon_if ();
    alloc_reg_if reg_if ();

    alloc_ptr_allocator alloc_ptr_allocator_inst (
        .clk, .ctrl_reset, .ctrl_en, .ctrl_alloc_en,
        .alloc_req, .dealloc_req, .dealloc_ptr,
        .alloc_gnt, .alloc_nack, .alloc_ptr,
        .init_done, .state,
        .mon_if (mon_if.peripheral)
    );

    alloc_ctrl_core alloc_ctrl_core_inst (
        .clk, .dbg_cnt_reset, .en, .init_done, .state,
        .ctrl_reset, .ctrl_en, .ctrl_alloc_en,
        .mon_if (mon_if.controller),
        .reg_if (reg_if.core)
    );

    alloc_reg_blk alloc_reg_blk_inst (
        .clk, .dbg_cnt_reset,
        .reg_wr, .reg_rd, .reg_addr, .reg_wdata,
        .reg_rdata, .reg_rvalid,
        .reg_if (reg_if.blk)
    );

endmodule : alloc_top

// File: verif/alloc_tb.sv
// ----------------------------------------------------------
// Allocator testbench
// Runs register, allocate and free commands from a stimulus
// file against the allocator top level
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "alloc_config.svh"

module alloc_tb;

    localparam int RD_LIMIT   = 8;
    localparam int GNT_LIMIT  = 8;
    localparam int POLL_LIMIT = 100;

    logic        clk;
    logic        dbg_cnt_reset;
    logic        reg_wr;
    logic        reg_rd;
    logic [7:0]  reg_addr;
    logic [31:0] reg_wdata;
    logic [31:0] reg_rdata;
    logic        reg_rvalid;
    logic        alloc_req;
    logic        alloc_gnt;
    logic [3:0]  alloc_ptr;
    logic        alloc_nack;
    logic        dealloc_req;
    logic [3:0]  dealloc_ptr;
    logic        en;

    int check_cnt;
    int error_cnt;
    int test_cnt;
    int bad_tests;
    int test_start_checks;
    int test_start_errors;
    bit timed_out;

    alloc_top alloc_top_inst (
        .clk, .dbg_cnt_reset,
        .reg_wr, .reg_rd, .reg_addr, .reg_wdata, .reg_rdata, .reg_rvalid,
        .alloc_req, .alloc_gnt, .alloc_ptr, .alloc_nack,
        .dealloc_req, .dealloc_ptr, .en
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------------------------------
    // Bus and request tasks, each starts on a falling edge
    // ------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("[ERROR] %s: expected 0x%0h, got 0x%0h", name, exp, got);
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_wr = 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        int waited;
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(negedge clk);
        reg_rd = 1'b0;
        waited = 0;
        while (!reg_rvalid && waited < RD_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!reg_rvalid) begin
            $display("Timeout: no read data for register 0x%02h", addr);
            timed_out = 1'b1;
        end
        data = reg_rdata;
    endtask

    // Read until the masked value matches, bounded by POLL_LIMIT reads
    task automatic poll_reg(input logic [7:0] addr, input logic [31:0] mask,
                            input logic [31:0] exp);
        int polls;
        logic [31:0] data;
        polls = 0;
        read_reg(addr, data);
        while (!timed_out && (data & mask) != exp && polls < POLL_LIMIT) begin
            read_reg(addr, data);
            polls++;
        end
        if (!timed_out && (data & mask) != exp) begin
            $display("Timeout: register 0x%02h never reached 0x%0h under mask 0x%0h",
                     addr, exp, mask);
            timed_out = 1'b1;
        end
    endtask

    task automatic request_alloc(input bit exp_gnt, input logic [3:0] exp_ptr);
        int waited;
        alloc_req = 1'b1;
        @(negedge clk);
        alloc_req = 1'b0;
        waited = 0;
        while (!alloc_gnt && !alloc_nack && waited < GNT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!alloc_gnt && !alloc_nack) begin
            $display("Timeout: no grant or nack after an allocate request");
            timed_out = 1'b1;
        end else begin
            check_value("alloc_gnt", 32'(exp_gnt), 32'(alloc_gnt));
            check_value("alloc_nack", 32'(!exp_gnt), 32'(alloc_nack));
            if (exp_gnt && alloc_gnt) begin
                check_value("alloc_ptr", 32'(exp_ptr), 32'(alloc_ptr));
            end
        end
    endtask

    task automatic free_pointer(input logic [3:0] ptr);
        dealloc_req = 1'b1;
        dealloc_ptr = ptr;
        @(negedge clk);
        dealloc_req = 1'b0;
    endtask

    // ------------------------------------------------------
    // One command of the stimulus file
    // ------------------------------------------------------
    task automatic run_command(input int fd, input logic [8*16-1:0] op);
        int code;
        logic [8*128-1:0] line;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] data;
        if (op == "#") begin
            code = $fgets(line, fd);
        end else if (op == "wr") begin
            code = $fscanf(fd, "%h %h", a, b);
            write_reg(a[7:0], b);
        end else if (op == "rd") begin
            code = $fscanf(fd, "%h %h", a, b);
            read_reg(a[7:0], data);
            if (!timed_out) begin
                check_value($sformatf("reg_rdata[0x%02h]", a[7:0]), b, data);
            end
        end else if (op == "poll") begin
            code = $fscanf(fd, "%h %h %h", a, b, c);
            poll_reg(a[7:0], b, c);
        end else if (op == "alloc") begin
            // Count, then the first expected pointer
            code = $fscanf(fd, "%h %h", a, b);
            for (int i = 0; i < a && !timed_out; i++) begin
                request_alloc(1'b1, 4'(b + i));
            end
        end else if (op == "nack") begin
            request_alloc(1'b0, 4'h0);
        end else if (op == "free") begin
            code = $fscanf(fd, "%h", a);
            free_pointer(a[3:0]);
        end else if (op == "idle") begin
            code = $fscanf(fd, "%h", a);
            repeat (a) @(negedge clk);
        end else if (op == "end") begin
            code = $fscanf(fd, "%h", a);
            test_cnt++;
            if (error_cnt == test_start_errors) begin
                $display("Test %0d: PASS, %0d checks", a, check_cnt - test_start_checks);
            end else begin
                bad_tests++;
                $display("Test %0d: FAIL, %0d errors", a, error_cnt - test_start_errors);
            end
            test_start_checks = check_cnt;
            test_start_errors = error_cnt;
        end else begin
            $display("Unknown command in the stimulus file: %0s", op);
            error_cnt++;
        end
    endtask

    initial begin
        int fd;
        int code;
        logic [8*16-1:0] op;
        logic [31:0] data;
        dbg_cnt_reset = 1'b1;
        en            = 1'b0;
        reg_wr        = 1'b0;
        reg_rd        = 1'b0;
        reg_addr      = '0;
        reg_wdata     = '0;
        alloc_req     = 1'b0;
        dealloc_req   = 1'b0;
        dealloc_ptr   = '0;
        check_cnt     = 0;
        error_cnt     = 0;
        test_cnt      = 0;
        bad_tests     = 0;
        test_start_checks = 0;
        test_start_errors = 0;
        timed_out     = 1'b0;

        repeat (4) @(negedge clk);
        dbg_cnt_reset = 1'b0;
        en            = 1'b1;

        // Replies idle after reset
        check_value("alloc_gnt", 32'h0, 32'(alloc_gnt));
        check_value("alloc_nack", 32'h0, 32'(alloc_nack));
        check_value("reg_rvalid", 32'h0, 32'(reg_rvalid));

        // Deallocate fail while the pool is not yet ready
        @(negedge clk);
        free_pointer(4'h0);
        repeat (3) @(negedge clk);
        read_reg(`REG_CNT_DEALLOC_FAIL, data);
        if (!timed_out) begin
            check_value("reg_rdata[0x30]", 32'h1, data);
        end

        fd = $fopen("verif/alloc_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file verif/alloc_stimulus.txt");
            error_cnt++;
        end else begin
            while (!timed_out && !$feof(fd)) begin
                code = $fscanf(fd, "%s", op);
                if (code == 1) begin
                    run_command(fd, op);
                end
            end
            $fclose(fd);
        end

        $display("Summary: %0d tests, %0d with errors, %0d checks, %0d errors",
                 test_cnt, bad_tests, check_cnt, error_cnt);
        if (timed_out || error_cnt != 0 || test_cnt == 0) begin
            $display("Test failed");
        end else begin
            $display("Test passed");
        end
        $finish;
    end

endmodule : alloc_tb

// File: verif/alloc_stimulus.txt
# Columns: command, then hex arguments
# wr addr data | rd addr expected | poll addr mask expected | alloc count first_ptr
# nack | free ptr | idle cycles | end test_number
# Reset and init
idle 2
rd 04 0
rd 00 0
wr 00 6
poll 04 2 2
rd 04 6
rd 38 10
rd 18 2
end 1
# Sixteen grants in order, then a nack on the full pool
alloc 10 0
nack
idle 3
rd 14 10
rd 24 1
rd 20 10
end 2
# Free 5 and 2, reuse 2, then free 2 twice
free 5
free 2
idle 3
rd 14 e
alloc 1 2
free 2
free 2
idle 3
rd 10 2
rd 14 e
rd 2c 3
rd 34 1
end 3
# Clear on read of the error flags
rd 08 2
rd 08 0
end 4
# Allocate error with allocate enable low
wr 00 2
nack
idle 3
rd 08 1
rd 28 1
rd 20 11
rd 0c 2
end 5
# Counter clear, then soft reset and a full pool again
wr 1c 1
idle 3
rd 20 0
rd 24 0
rd 28 0
rd 2c 0
rd 30 0
rd 34 0
rd 14 e
wr 00 7
poll 04 2 0
wr 00 6
poll 04 2 2
rd 14 0
alloc 10 0
nack
idle 3
rd 20 10
rd 24 1
end 6

// File: vlog.f
+incdir+include
hdl/alloc_pkg.sv
hdl/alloc_mon_if.sv
hdl/alloc_reg_if.sv
hdl/alloc_ptr_allocator.sv
hdl/alloc_reg_blk.sv
hdl/alloc_ctrl_core.sv
hdl/alloc_top.sv
verif/alloc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the allocator testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f vlog.f --top-module alloc_tb \
    --Mdir obj_dir -o alloc_sim > sim.log 2>&1 \
    && ./obj_dir/alloc_sim >> sim.log 2>&1 \
    || { cat sim.log; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || exit 1
exit 0
